// File: verif/vid_patterns.txt
# kind address data expected, all hex
# W cpu write, R cpu read, L line (address burst start, data 1 vblank first, expected words), P pixel x colour
W 00F00000 00000124 00000000
W 00F00004 00000040 00000000
W 00F00008 00000003 00000000
R 00F00000 00000000 00000124
R 00F00004 00000000 00000040
R 00F00008 00000000 00000003
W 00F00000 00000000 00000000
W 00F00004 00000008 00000000
W 00F00008 00000000 00000000
W 00E00004 00112233 00000000
W 00E00008 00445566 00000000
W 00E0000C 00778899 00000000
W 00E00010 00AABBCC 00000000
W 00000000 04030201 00000000
W 00000004 01020304 00000000
W 00000008 01010303 00000000
W 0000000C 02040204 00000000
W 00000100 04040404 00000000
W 00000104 01020301 00000000
R 00000000 00000000 04030201
R 00000008 00000000 01010303
R 00000040 00000000 5010A010
L 00000000 00000001 00000002
P 00000000 00000000 00112233
P 00000001 00000000 00445566
P 00000002 00000000 00778899
P 00000003 00000000 00AABBCC
P 00000006 00000000 00445566
P 00000007 00000000 00112233
W 00F00008 00000001 00000000
P 00000000 00000000 00112233
P 00000001 00000000 00112233
P 00000002 00000000 00445566
P 00000003 00000000 00445566
P 00000006 00000000 00AABBCC
P 0000000A 00000000 00778899
P 0000000B 00000000 00778899
W 00F00008 00000002 00000000
L 00000000 00000001 00000002
L 00000000 00000000 00000000
P 00000000 00000000 00112233
P 00000005 00000000 00778899
L 00000008 00000000 00000002
P 00000000 00000000 00778899
P 00000005 00000000 00445566
P 00000006 00000000 00AABBCC
W 00F00008 00000000 00000000
W 00F00000 00000100 00000000
L 00000100 00000001 00000002
P 00000000 00000000 00AABBCC
P 00000005 00000000 00778899
P 00000007 00000000 00112233

// File: files.f
common/vid_pkg.sv
design/vid_bram_1r1w.sv
cpu_port/vid_cpu_decode.sv
scanout/vid_line_fetch.sv
scanout/vid_pixel_out.sv
design/vid_controller.sv
verif/vid_clock_gen.sv
verif/vid_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module vid_tb -o vid_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/vid_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^>>> PASS$"; then
	exit 0
fi
exit 1

// File: verif/vid_tb.sv
`timescale 1ns/1ps

module vid_tb
	import vid_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int VRAM_WORDS = 4096;

	logic                   clock;
	logic                   rst_n;
	logic                   cpu_request;
	logic                   cpu_rw;
	logic [VID_DATA_W-1:0]  cpu_address;
	logic [VID_DATA_W-1:0]  cpu_wdata;
	logic [VID_DATA_W-1:0]  cpu_rdata;
	logic                   cpu_ready;
	logic                   video_hblank;
	logic                   video_vblank;
	logic [VID_POS_W-1:0]   video_pos_x;
	logic [VID_DATA_W-1:0]  video_rdata;
	logic                   pa_request;
	logic                   pa_rw;
	logic [VID_DATA_W-1:0]  pa_address;
	logic [VID_DATA_W-1:0]  pa_wdata;
	logic [VID_DATA_W-1:0]  pa_rdata;
	logic                   pa_ready;
	logic                   pb_request;
	logic [VID_DATA_W-1:0]  pb_address;
	logic [VID_DATA_W-1:0]  pb_rdata;
	logic                   pb_ready;

	logic [VID_DATA_W-1:0]  vram [VRAM_WORDS];
	logic [31:0]            lfsr = 32'hfdf1b5c9;
	logic                   pa_busy = 1'b0;
	int                     pa_wait = 0;
	int                     pb_wait = 0;
	logic                   pb_seen = 1'b0;
	logic [VID_DATA_W-1:0]  beat_count = '0;
	logic [VID_DATA_W-1:0]  first_pb_address = '0;
	logic                   ops_loaded = 1'b0;

	byte                    op_kind [$];
	logic [VID_DATA_W-1:0]  op_addr [$];
	logic [VID_DATA_W-1:0]  op_data [$];
	logic [VID_DATA_W-1:0]  op_exp  [$];

	vid_clock_gen #(
		.PERIOD_NS    (CLK_PERIOD),
		.RESET_CYCLES (10)
	) u_clock_gen (
		.o_clock (clock),
		.o_rst_n (rst_n)
	);

	vid_controller #(
		.MAX_PITCH (640)
	) dut0 (
		.i_clock           (clock),
		.i_rst_n           (rst_n),
		.i_cpu_request     (cpu_request),
		.i_cpu_rw          (cpu_rw),
		.i_cpu_address     (cpu_address),
		.i_cpu_wdata       (cpu_wdata),
		.o_cpu_rdata       (cpu_rdata),
		.o_cpu_ready       (cpu_ready),
		.i_video_hblank    (video_hblank),
		.i_video_vblank    (video_vblank),
		.i_video_pos_x     (video_pos_x),
		.o_video_rdata     (video_rdata),
		.o_vram_pa_request (pa_request),
		.o_vram_pa_rw      (pa_rw),
		.o_vram_pa_address (pa_address),
		.o_vram_pa_wdata   (pa_wdata),
		.i_vram_pa_rdata   (pa_rdata),
		.i_vram_pa_ready   (pa_ready),
		.o_vram_pb_request (pb_request),
		.o_vram_pb_address (pb_address),
		.i_vram_pb_rdata   (pb_rdata),
		.i_vram_pb_ready   (pb_ready)
	);

	// ===================================================================
	// Helpers
	// ===================================================================

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return (state >> 1) ^ (state[0] ? 32'hA3000000 : 32'h0);
	endfunction

	task automatic draw_random(input int nbits, output logic [31:0] value);
		int b;
		value = '0;
		for (b = 0; b < nbits; b++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic stop_on_error();
		$display(">>> FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [VID_DATA_W-1:0] got,
		input logic [VID_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_color(input string name, input logic [VID_COLOR_W-1:0] got,
		input logic [VID_COLOR_W-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic wait_cycle();
		@(posedge clock);
		#2;
	endtask

	// ===================================================================
	// VRAM model for both ports
	// ===================================================================

	always @(posedge clock) begin
		logic [31:0] rnd;
		#1;
		if (pa_ready) begin
			pa_ready = 1'b0;
		end else if (pa_request) begin
			if (!pa_busy) begin
				pa_busy = 1'b1;
				draw_random(2, rnd);
				pa_wait = int'(rnd[1:0]);
			end
			if (pa_wait == 0) begin
				if (pa_rw) begin
					vram[pa_address[13:2]] = pa_wdata;
				end
				pa_rdata = vram[pa_address[13:2]];
				pa_ready = 1'b1;
				pa_busy  = 1'b0;
			end else begin
				pa_wait = pa_wait - 1;
			end
		end

		// Each ready beat is taken at the next edge
		if (!pb_request) begin
			pb_ready = 1'b0;
		end else begin
			pb_seen = 1'b1;
			if (pb_wait != 0) begin
				pb_wait  = pb_wait - 1;
				pb_ready = 1'b0;
			end else begin
				if (beat_count == '0) begin
					first_pb_address = pb_address;
				end
				beat_count = beat_count + 32'd1;
				pb_rdata   = vram[pb_address[13:2]];
				pb_ready   = 1'b1;
				draw_random(2, rnd);
				pb_wait = int'(rnd[1:0]);
			end
		end
	end

	// ===================================================================
	// Operations
	// ===================================================================

	task automatic load_patterns();
		int fd;
		int n;
		string line;
		string kind;
		logic [VID_DATA_W-1:0] a;
		logic [VID_DATA_W-1:0] d;
		logic [VID_DATA_W-1:0] e;
		fd = $fopen("verif/vid_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file verif/vid_patterns.txt");
			stop_on_error();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %h %h %h", kind, a, d, e);
					if (n == 4) begin
						op_kind.push_back(kind.getc(0));
						op_addr.push_back(a);
						op_data.push_back(d);
						op_exp.push_back(e);
					end else if (n > 0) begin
						$display("Malformed pattern line: %s", line);
						stop_on_error();
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic cpu_access(input logic rw, input logic [VID_DATA_W-1:0] address,
		input logic [VID_DATA_W-1:0] wdata, output logic [VID_DATA_W-1:0] rdata);
		cpu_request = 1'b1;
		cpu_rw      = rw;
		cpu_address = address;
		cpu_wdata   = wdata;
		do begin
			wait_cycle();
		end while (!cpu_ready);
		rdata       = cpu_rdata;
		cpu_request = 1'b0;
		do begin
			wait_cycle();
		end while (cpu_ready);
	endtask

	task automatic run_line(input logic [VID_DATA_W-1:0] exp_address, input logic vblank_first,
		input logic [VID_DATA_W-1:0] exp_words);
		if (vblank_first) begin
			video_vblank = 1'b1;
			repeat (3) wait_cycle();
			video_vblank = 1'b0;
			repeat (3) wait_cycle();
		end
		beat_count   = '0;
		pb_seen      = 1'b0;
		video_hblank = 1'b1;
		if (exp_words == '0) begin
			// Repeated line, port B stays idle
			repeat (6) wait_cycle();
			if (pb_seen) begin
				$display("Port B burst started on a line that should have been repeated");
				stop_on_error();
			end
		end else begin
			while (!pb_request) begin
				wait_cycle();
			end
			while (pb_request) begin
				wait_cycle();
			end
			check_word("port B burst length", beat_count, exp_words);
			check_word("o_vram_pb_address", first_pb_address, exp_address);
		end
		video_hblank = 1'b0;
		repeat (3) wait_cycle();
	endtask

	task automatic sample_pixel(input logic [VID_DATA_W-1:0] x,
		input logic [VID_COLOR_W-1:0] exp);
		video_pos_x = x[VID_POS_W-1:0];
		repeat (3) wait_cycle();
		check_color("o_video_rdata", video_rdata[VID_COLOR_W-1:0], exp);
		if (video_rdata[VID_DATA_W-1:VID_COLOR_W] !== '0) begin
			$display("Fail at %0t ns: o_video_rdata upper bits are %h, expected 00", $time,
				video_rdata[VID_DATA_W-1:VID_COLOR_W]);
			stop_on_error();
		end
	endtask

	// Watchdog sized from the number of operations
	initial begin
		longint limit;
		wait (ops_loaded);
		limit = 200 * op_kind.size() + 2000;
		#(limit * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		stop_on_error();
	end

	initial begin
		int i;
		logic [VID_DATA_W-1:0] rdata;
		cpu_request  = 1'b0;
		cpu_rw       = 1'b0;
		cpu_address  = '0;
		cpu_wdata    = '0;
		video_hblank = 1'b0;
		video_vblank = 1'b0;
		video_pos_x  = '0;
		pa_rdata     = '0;
		pa_ready     = 1'b0;
		pb_rdata     = '0;
		pb_ready     = 1'b0;
		for (i = 0; i < VRAM_WORDS; i++) begin
			vram[i] = {4'h5, 12'(i), 4'hA, 12'(i)};
		end
		load_patterns();
		ops_loaded = 1'b1;

		@(posedge rst_n);
		wait_cycle();
		for (i = 0; i < op_kind.size(); i++) begin
			case (op_kind[i])
				"W": cpu_access(1'b1, op_addr[i], op_data[i], rdata);
				"R": begin
					cpu_access(1'b0, op_addr[i], '0, rdata);
					check_word("o_cpu_rdata", rdata, op_exp[i]);
				end
				"L": run_line(op_addr[i], op_data[i][0], op_exp[i]);
				"P": sample_pixel(op_addr[i], op_exp[i][VID_COLOR_W-1:0]);
				default: begin
					$display("Unknown operation kind in pattern line %0d", i);
					stop_on_error();
				end
			endcase
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: verif/vid_clock_gen.sv
`timescale 1ns/1ps

module vid_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic o_clock,
	output logic o_rst_n
);

	initial begin
		o_clock = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			o_clock = ~o_clock;
		end
	end

	// Release just after a rising edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clock);
		#2;
		o_rst_n = 1'b1;
	end

endmodule

// File: design/vid_controller.sv
`timescale 1ns/1ps

module vid_controller
	import vid_pkg::*;
#(
	parameter int MAX_PITCH = 640
) (
	input  logic                  i_clock,
	input  logic                  i_rst_n,

	input  logic                  i_cpu_request,
	input  logic                  i_cpu_rw,
	input  logic [VID_DATA_W-1:0] i_cpu_address,
	input  logic [VID_DATA_W-1:0] i_cpu_wdata,
	output logic [VID_DATA_W-1:0] o_cpu_rdata,
	output logic                  o_cpu_ready,

	input  logic                  i_video_hblank,
	input  logic                  i_video_vblank,
	input  logic [VID_POS_W-1:0]  i_video_pos_x,
	output logic [VID_DATA_W-1:0] o_video_rdata,

	output logic                  o_vram_pa_request,
	output logic                  o_vram_pa_rw,
	output logic [VID_DATA_W-1:0] o_vram_pa_address,
	output logic [VID_DATA_W-1:0] o_vram_pa_wdata,
	input  logic [VID_DATA_W-1:0] i_vram_pa_rdata,
	input  logic                  i_vram_pa_ready,

	output logic                  o_vram_pb_request,
	output logic [VID_DATA_W-1:0] o_vram_pb_address,
	input  logic [VID_DATA_W-1:0] i_vram_pb_rdata,
	input  logic                  i_vram_pb_ready
);

	localparam int LINE_DEPTH = MAX_PITCH / 4;
	localparam int LINE_AW    = $clog2(LINE_DEPTH);

	logic [VID_DATA_W-1:0]  read_offset;
	logic [VID_DATA_W-1:0]  pitch;
	logic [1:0]             skip;

	logic                   pal_we;
	logic [7:0]             pal_index;
	logic [VID_COLOR_W-1:0] pal_color;
	logic [7:0]             pal_raddr;
	logic [VID_COLOR_W-1:0] pal_rdata;

	logic                   line_we;
	logic [LINE_AW-1:0]     line_waddr;
	vid_line_word_u         line_wword;
	logic [VID_POS_W-3:0]   line_raddr;
	vid_line_word_u         line_rword;

	// ===================================================================
	// CPU side
	// ===================================================================

	vid_cpu_decode u_decode (
		.i_clock           (i_clock),
		.i_rst_n           (i_rst_n),
		.i_cpu_request     (i_cpu_request),
		.i_cpu_rw          (i_cpu_rw),
		.i_cpu_address     (i_cpu_address),
		.i_cpu_wdata       (i_cpu_wdata),
		.o_cpu_rdata       (o_cpu_rdata),
		.o_cpu_ready       (o_cpu_ready),
		.o_vram_pa_request (o_vram_pa_request),
		.o_vram_pa_rw      (o_vram_pa_rw),
		.o_vram_pa_address (o_vram_pa_address),
		.o_vram_pa_wdata   (o_vram_pa_wdata),
		.i_vram_pa_rdata   (i_vram_pa_rdata),
		.i_vram_pa_ready   (i_vram_pa_ready),
		.o_pal_we          (pal_we),
		.o_pal_index       (pal_index),
		.o_pal_color       (pal_color),
		.o_read_offset     (read_offset),
		.o_pitch           (pitch),
		.o_skip            (skip)
	);

	vid_bram_1r1w #(
		.WIDTH (VID_COLOR_W),
		.DEPTH (256)
	) u_palette (
		.i_clock (i_clock),
		.i_raddr (pal_raddr),
		.o_rdata (pal_rdata),
		.i_we    (pal_we),
		.i_waddr (pal_index),
		.i_wdata (pal_color)
	);

	// ===================================================================
	// Scan-out
	// ===================================================================

	vid_line_fetch #(
		.MAX_PITCH (MAX_PITCH)
	) u_fetch (
		.i_clock           (i_clock),
		.i_rst_n           (i_rst_n),
		.i_video_hblank    (i_video_hblank),
		.i_video_vblank    (i_video_vblank),
		.i_read_offset     (read_offset),
		.i_pitch           (pitch),
		.i_skip            (skip),
		.o_vram_pb_request (o_vram_pb_request),
		.o_vram_pb_address (o_vram_pb_address),
		.i_vram_pb_rdata   (i_vram_pb_rdata),
		.i_vram_pb_ready   (i_vram_pb_ready),
		.o_line_we         (line_we),
		.o_line_addr       (line_waddr),
		.o_line_word       (line_wword)
	);

	vid_bram_1r1w #(
		.WIDTH (VID_DATA_W),
		.DEPTH (LINE_DEPTH)
	) u_line (
		.i_clock (i_clock),
		.i_raddr (line_raddr[LINE_AW-1:0]),
		.o_rdata (line_rword),
		.i_we    (line_we),
		.i_waddr (line_waddr),
		.i_wdata (line_wword)
	);

	vid_pixel_out u_pixel (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_video_pos_x (i_video_pos_x),
		.i_skip_h      (skip[SKIP_DOUBLE_X]),
		.o_line_raddr  (line_raddr),
		.i_line_word   (line_rword),
		.o_pal_raddr   (pal_raddr),
		.i_pal_color   (pal_rdata),
		.o_video_rdata (o_video_rdata)
	);

endmodule

// File: scanout/vid_pixel_out.sv
`timescale 1ns/1ps

module vid_pixel_out
	import vid_pkg::*;
(
	input  logic                   i_clock,
	input  logic                   i_rst_n,

	input  logic [VID_POS_W-1:0]   i_video_pos_x,
	input  logic                   i_skip_h,

	output logic [VID_POS_W-3:0]   o_line_raddr,
	input  vid_line_word_u         i_line_word,

	output logic [7:0]             o_pal_raddr,
	input  logic [VID_COLOR_W-1:0] i_pal_color,

	output logic [VID_DATA_W-1:0]  o_video_rdata
);

	logic [1:0] lane;
	logic [1:0] lane_q;

	// Pixel doubling halves the x mapping
	always_comb begin
		if (i_skip_h) begin
			o_line_raddr = {1'b0, i_video_pos_x[VID_POS_W-1:3]};
			lane         = i_video_pos_x[2:1];
		end else begin
			o_line_raddr = i_video_pos_x[VID_POS_W-1:2];
			lane         = i_video_pos_x[1:0];
		end
	end

	// Lane lines up with the line buffer read data
	assign o_pal_raddr = i_line_word.pix[lane_q];

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lane_q        <= 2'd0;
			o_video_rdata <= '0;
		end else begin
			lane_q        <= lane;
			o_video_rdata <= {{(VID_DATA_W-VID_COLOR_W){1'b0}}, i_pal_color};
		end
	end

endmodule

// File: scanout/vid_line_fetch.sv
`timescale 1ns/1ps

module vid_line_fetch
	import vid_pkg::*;
#(
	parameter int  MAX_PITCH = 640,
	localparam int LINE_AW   = $clog2(MAX_PITCH / 4)
) (
	input  logic                  i_clock,
	input  logic                  i_rst_n,

	input  logic                  i_video_hblank,
	input  logic                  i_video_vblank,

	input  logic [VID_DATA_W-1:0] i_read_offset,
	input  logic [VID_DATA_W-1:0] i_pitch,
	input  logic [1:0]            i_skip,

	output logic                  o_vram_pb_request,
	output logic [VID_DATA_W-1:0] o_vram_pb_address,
	input  logic [VID_DATA_W-1:0] i_vram_pb_rdata,
	input  logic                  i_vram_pb_ready,

	output logic                  o_line_we,
	output logic [LINE_AW-1:0]    o_line_addr,
	output vid_line_word_u        o_line_word
);

	logic [1:0]            hs;
	logic [1:0]            vs;
	logic [VID_DATA_W-1:0] row;
	logic                  line_odd;
	logic [LINE_AW-1:0]    column;
	logic [VID_DATA_W-3:0] burst_words;
	logic                  hblank_rise;
	logic                  vblank_fall;
	logic                  last_word;
	logic                  fetch_go;

	// Blank edges from the two-bit history
	assign hblank_rise = (hs == 2'b01) && (vs == 2'b00);
	assign vblank_fall = (vs == 2'b10);

	assign burst_words = i_pitch[VID_DATA_W-1:2];
	assign last_word   = ((VID_DATA_W-2)'(column) + 1'b1) == burst_words;

	// Odd lines are skipped when line repeat is on
	assign fetch_go = hblank_rise && (!i_skip[SKIP_REPEAT_Y] || !line_odd) &&
	                  !o_vram_pb_request && (burst_words != '0);

	// ===================================================================
	// Row stepping and port B burst
	// ===================================================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hs                <= 2'b00;
			vs                <= 2'b00;
			row               <= '0;
			line_odd          <= 1'b0;
			column            <= '0;
			o_vram_pb_request <= 1'b0;
			o_vram_pb_address <= '0;
			o_line_we         <= 1'b0;
		end else begin
			hs        <= {hs[0], i_video_hblank};
			vs        <= {vs[0], i_video_vblank};
			o_line_we <= 1'b0;

			if (vblank_fall) begin
				row      <= '0;
				line_odd <= 1'b0;
			end
			if (hblank_rise) begin
				line_odd <= !line_odd;
			end

			if (fetch_go) begin
				o_vram_pb_request <= 1'b1;
				o_vram_pb_address <= i_read_offset + row;
				row               <= row + i_pitch;
				column            <= '0;
			end else if (o_vram_pb_request && i_vram_pb_ready) begin
				o_line_we         <= 1'b1;
				column            <= column + 1'b1;
				o_vram_pb_address <= o_vram_pb_address + 32'd4;
				if (last_word) begin
					o_vram_pb_request <= 1'b0;
				end
			end
		end
	end

	// Line buffer write data
	always_ff @(posedge i_clock) begin
		if (o_vram_pb_request && i_vram_pb_ready) begin
			o_line_addr      <= column;
			o_line_word.word <= i_vram_pb_rdata;
		end
	end

endmodule

// File: cpu_port/vid_cpu_decode.sv
`timescale 1ns/1ps

module vid_cpu_decode
	import vid_pkg::*;
(
	input  logic                   i_clock,
	input  logic                   i_rst_n,

	input  logic                   i_cpu_request,
	input  logic                   i_cpu_rw,
	input  logic [VID_DATA_W-1:0]  i_cpu_address,
	input  logic [VID_DATA_W-1:0]  i_cpu_wdata,
	output logic [VID_DATA_W-1:0]  o_cpu_rdata,
	output logic                   o_cpu_ready,

	output logic                   o_vram_pa_request,
	output logic                   o_vram_pa_rw,
	output logic [VID_DATA_W-1:0]  o_vram_pa_address,
	output logic [VID_DATA_W-1:0]  o_vram_pa_wdata,
	input  logic [VID_DATA_W-1:0]  i_vram_pa_rdata,
	input  logic                   i_vram_pa_ready,

	output logic                   o_pal_we,
	output logic [7:0]             o_pal_index,
	output logic [VID_COLOR_W-1:0] o_pal_color,

	output logic [VID_DATA_W-1:0]  o_read_offset,
	output logic [VID_DATA_W-1:0]  o_pitch,
	output logic [1:0]             o_skip
);

	localparam logic [2:0] ST_IDLE    = 3'd0;
	localparam logic [2:0] ST_VRAM    = 3'd1;
	localparam logic [2:0] ST_PAL     = 3'd2;
	localparam logic [2:0] ST_CTRL    = 3'd3;
	localparam logic [2:0] ST_RELEASE = 3'd4;

	logic [2:0]            state;
	vid_region_e           region;
	vid_reg_e              reg_sel;
	logic [VID_DATA_W-1:0] ctrl_rdata;

	always_comb begin
		if (i_cpu_address[23:20] == REGION_PALETTE) begin
			region = REGION_PALETTE;
		end else if (i_cpu_address[23:20] == REGION_CONTROL) begin
			region = REGION_CONTROL;
		end else begin
			region = REGION_VRAM;
		end
	end

	assign reg_sel = vid_reg_e'(i_cpu_address[3:2]);

	// Register readback
	always_comb begin
		case (reg_sel)
			REG_OFFSET: ctrl_rdata = o_read_offset;
			REG_PITCH:  ctrl_rdata = o_pitch;
			REG_SKIP:   ctrl_rdata = {{(VID_DATA_W-2){1'b0}}, o_skip};
			default:    ctrl_rdata = '0;
		endcase
	end

	// ===================================================================
	// Access FSM
	// ===================================================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state             <= ST_IDLE;
			o_cpu_ready       <= 1'b0;
			o_cpu_rdata       <= '0;
			o_vram_pa_request <= 1'b0;
			o_vram_pa_rw      <= 1'b0;
			o_vram_pa_address <= '0;
			o_vram_pa_wdata   <= '0;
			o_pal_we          <= 1'b0;
			o_pal_index       <= '0;
			o_pal_color       <= '0;
			o_read_offset     <= '0;
			o_pitch           <= '0;
			o_skip            <= '0;
		end else begin
			o_cpu_ready <= 1'b0;
			o_pal_we    <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_cpu_request) begin
						case (region)
							REGION_PALETTE: begin
								// Palette is write only
								o_pal_we    <= i_cpu_rw;
								o_pal_index <= i_cpu_address[9:2];
								o_pal_color <= i_cpu_wdata[VID_COLOR_W-1:0];
								state       <= ST_PAL;
							end
							REGION_CONTROL: begin
								state <= ST_CTRL;
							end
							default: begin
								o_vram_pa_request <= 1'b1;
								o_vram_pa_rw      <= i_cpu_rw;
								o_vram_pa_address <= {8'h00, i_cpu_address[23:0]};
								o_vram_pa_wdata   <= i_cpu_wdata;
								state             <= ST_VRAM;
							end
						endcase
					end
				end
				ST_VRAM: begin
					if (i_vram_pa_ready) begin
						o_vram_pa_request <= 1'b0;
						o_cpu_rdata       <= i_vram_pa_rdata;
						o_cpu_ready       <= 1'b1;
						state             <= ST_RELEASE;
					end
				end
				ST_PAL: begin
					o_cpu_rdata <= '0;
					o_cpu_ready <= 1'b1;
					state       <= ST_RELEASE;
				end
				ST_CTRL: begin
					if (i_cpu_rw) begin
						case (reg_sel)
							REG_OFFSET: o_read_offset <= i_cpu_wdata;
							REG_PITCH:  o_pitch       <= i_cpu_wdata;
							REG_SKIP:   o_skip        <= i_cpu_wdata[1:0];
							default:    ;
						endcase
					end
					o_cpu_rdata <= ctrl_rdata;
					o_cpu_ready <= 1'b1;
					state       <= ST_RELEASE;
				end
				ST_RELEASE: begin
					// Hold ready until the CPU lets go
					o_cpu_ready <= i_cpu_request;
					if (!i_cpu_request) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: design/vid_bram_1r1w.sv
`timescale 1ns/1ps

module vid_bram_1r1w #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 256
) (
	input  logic                     i_clock,
	input  logic [$clog2(DEPTH)-1:0] i_raddr,
	output logic [WIDTH-1:0]         o_rdata,
	input  logic                     i_we,
	input  logic [$clog2(DEPTH)-1:0] i_waddr,
	input  logic [WIDTH-1:0]         i_wdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge i_clock) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// Read data registered every cycle
	always_ff @(posedge i_clock) begin
		o_rdata <= mem[i_raddr];
	end

endmodule

// File: common/vid_pkg.sv
package vid_pkg;

	localparam int VID_DATA_W  = 32;
	localparam int VID_POS_W   = 11;
	localparam int VID_COLOR_W = 24;

	// Skip field bit positions
	localparam int SKIP_DOUBLE_X = 0;
	localparam int SKIP_REPEAT_Y = 1;

	// ===================================================================
	// CPU address decode
	// ===================================================================

	// Region from address bits 23:20, anything not E or F is VRAM
	typedef enum logic [3:0] {
		REGION_VRAM    = 4'h0,
		REGION_PALETTE = 4'hE,
		REGION_CONTROL = 4'hF
	} vid_region_e;

	// Register index from address bits 3:2
	typedef enum logic [1:0] {
		REG_OFFSET = 2'd0,
		REG_PITCH  = 2'd1,
		REG_SKIP   = 2'd2
	} vid_reg_e;

	// One line buffer entry, pix[0] is the leftmost pixel
	typedef union packed {
		logic [VID_DATA_W-1:0] word;
		logic [3:0][7:0]       pix;
	} vid_line_word_u;

endpackage
